/* hdl/audio_defs.svh */
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// number of playback channels walked per frame.
`define AUDIO_CHANNELS 4

// sample word address into external memory.
`define AUDIO_ADDR_WIDTH 20

// clk cycles per half bit clock; 32 bit clocks make one frame.
`define AUDIO_BCLK_HALF 2

// bits per PCM sample word.
`define AUDIO_SAMPLE_WIDTH 16

`endif

/* hdl/audio_pkg.sv */
`default_nettype none

package audio_pkg;

`include "audio_defs.svh"

    typedef logic signed [`AUDIO_SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [`AUDIO_SAMPLE_WIDTH:0]   scaled_t;   // sample after volume.
    typedef logic [`AUDIO_ADDR_WIDTH-1:0]          addr_t;
    typedef logic [$clog2(`AUDIO_CHANNELS)-1:0]    chan_t;
    typedef logic [7:0]                            volume_t;

    typedef enum logic [3:0] {
        set_start_address    = 4'd1,
        set_sample_count     = 4'd2,
        set_loop_start       = 4'd3,
        set_loop_end         = 4'd4,
        set_current_position = 4'd5,
        set_volume           = 4'd7,   // 6 was the old last-sample slot.
        set_is_looping       = 4'd8,
        set_is_playing       = 4'd9,
        set_is_mono          = 4'd10,
        set_is_right         = 4'd11
    } reg_sel_t;

    typedef enum logic [1:0] {
        idle,
        request,
        wait_data,
        update
    } fetch_state_t;

    typedef struct packed {
        logic        valid;
        chan_t       channel;
        reg_sel_t    select;
        logic [31:0] data;
    } reg_write_t;

    typedef struct packed {
        addr_t   start_address;
        addr_t   sample_count;
        addr_t   loop_start;
        addr_t   loop_end;
        addr_t   position;
        volume_t volume;
        logic    is_looping;
        logic    is_playing;
        logic    is_mono;
        logic    is_right;
    } channel_cfg_t;

    typedef struct packed {
        logic  valid;
        chan_t channel;
        addr_t position;
        logic  stop;
    } position_update_t;

    typedef struct packed {
        logic    valid;
        scaled_t sample;
        logic    to_left;
        logic    to_right;
    } mix_sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

endpackage

`default_nettype wire

/* hdl/channel_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_defs.svh"

module channel_regs import audio_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst,
    input  reg_write_t                              ctrl_write,
    input  position_update_t                        pos_update,
    output channel_cfg_t [`AUDIO_CHANNELS-1:0]      cfg
);

    chan_t   wr_ch;
    addr_t   wr_addr;
    volume_t wr_volume;
    logic    wr_flag;
    logic    write_hit;

    assign wr_ch     = ctrl_write.channel;
    assign wr_addr   = ctrl_write.data[`AUDIO_ADDR_WIDTH-1:0];
    assign wr_volume = ctrl_write.data[7:0];
    assign wr_flag   = ctrl_write.data[0];

    // a host write to the same channel overrides the sequencer.
    assign write_hit = ctrl_write.valid && (ctrl_write.channel == pos_update.channel);

    always_ff @(posedge clk) begin
        if (!rst) begin
            cfg <= '0;   // all channels stopped, volume zero.
        end else begin
            if (pos_update.valid && !write_hit) begin
                cfg[pos_update.channel].position <= pos_update.position;
                if (pos_update.stop) begin
                    cfg[pos_update.channel].is_playing <= 1'b0;   // end of sample.
                end
            end
            if (ctrl_write.valid) begin
                case (ctrl_write.select)
                    set_start_address: begin
                        cfg[wr_ch].start_address <= wr_addr;
                    end
                    set_sample_count: begin
                        cfg[wr_ch].sample_count <= wr_addr;
                    end
                    set_loop_start: begin
                        cfg[wr_ch].loop_start <= wr_addr;
                    end
                    set_loop_end: begin
                        cfg[wr_ch].loop_end <= wr_addr;
                    end
                    set_current_position: begin
                        cfg[wr_ch].position <= wr_addr;
                    end
                    set_volume: begin
                        cfg[wr_ch].volume <= wr_volume;
                    end
                    set_is_looping: begin
                        cfg[wr_ch].is_looping <= wr_flag;
                    end
                    set_is_playing: begin
                        cfg[wr_ch].is_playing <= wr_flag;
                    end
                    set_is_mono: begin
                        cfg[wr_ch].is_mono <= wr_flag;
                    end
                    set_is_right: begin
                        cfg[wr_ch].is_right <= wr_flag;
                    end
                    default: begin
                        // unused selects are ignored
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/sample_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_defs.svh"

module sample_fetch import audio_pkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                frame_start,
    input  channel_cfg_t [`AUDIO_CHANNELS-1:0]  cfg,
    output addr_t                               araddr,
    output logic                                arvalid,
    input  logic                                arready,
    input  sample_t                             rdata,
    input  logic                                rvalid,
    output logic                                rready,
    output mix_sample_t                         mix,
    output logic                                mix_done,
    output position_update_t                    pos_update
);

    fetch_state_t state;
    chan_t        ch;
    channel_cfg_t cur;
    addr_t        next_pos;
    logic         at_end;
    logic signed [`AUDIO_SAMPLE_WIDTH+8:0] product;

    assign cur     = cfg[ch];
    assign product = rdata * $signed({1'b0, cur.volume});   // unsigned gain.

    // position rule applied after each read.
    always_comb begin
        next_pos = cur.position + addr_t'(1);
        at_end   = 1'b0;
        if (cur.is_looping && (cur.position == cur.loop_end)) begin
            next_pos = cur.loop_start;
        end else if (cur.position == (cur.sample_count - addr_t'(1))) begin
            next_pos = cur.position;
            at_end   = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= idle;
            ch         <= '0;
            araddr     <= '0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            mix        <= '0;
            mix_done   <= 1'b0;
            pos_update <= '0;
        end else begin
            mix.valid        <= 1'b0;
            pos_update.valid <= 1'b0;
            mix_done         <= 1'b0;
            case (state)
                idle: begin
                    if (frame_start) begin
                        ch    <= '0;
                        state <= request;
                    end
                end
                request: begin
                    if (arvalid) begin
                        if (arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                            state   <= wait_data;
                        end
                    end else if (cur.is_playing) begin
                        arvalid <= 1'b1;
                        araddr  <= cur.start_address + cur.position;
                    end else begin
                        state <= update;   // stopped channel, no read.
                    end
                end
                wait_data: begin
                    if (rvalid) begin
                        rready              <= 1'b0;
                        mix.valid           <= 1'b1;
                        mix.sample          <= product[`AUDIO_SAMPLE_WIDTH+8:8];
                        mix.to_left         <= cur.is_mono || !cur.is_right;
                        mix.to_right        <= cur.is_mono || cur.is_right;
                        pos_update.valid    <= 1'b1;
                        pos_update.channel  <= ch;
                        pos_update.position <= next_pos;
                        pos_update.stop     <= at_end;
                        state               <= update;
                    end
                end
                update: begin
                    if (ch == chan_t'(`AUDIO_CHANNELS - 1)) begin
                        mix_done <= 1'b1;   // one cycle after the last sample.
                        state    <= idle;
                    end else begin
                        ch    <= ch + chan_t'(1);
                        state <= request;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // address must be held until the slave accepts it.
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

`default_nettype wire

/* hdl/channel_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_defs.svh"

module channel_mixer import audio_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        frame_start,
    input  mix_sample_t mix,
    input  logic        mix_done,
    output stereo_t     mix_out
);

    localparam int acc_w = `AUDIO_SAMPLE_WIDTH + 4;   // headroom for every channel.

    typedef logic signed [acc_w-1:0] acc_t;

    localparam acc_t sat_max = acc_t'((1 <<< (`AUDIO_SAMPLE_WIDTH - 1)) - 1);
    localparam acc_t sat_min = -sat_max - acc_t'(1);

    acc_t acc_left;
    acc_t acc_right;
    logic mix_pending;

    function automatic sample_t saturate(input acc_t sum);
        if (sum > sat_max) begin
            return sample_t'(sat_max);
        end else if (sum < sat_min) begin
            return sample_t'(sat_min);
        end
        return sample_t'(sum);
    endfunction

    always_ff @(posedge clk) begin
        if (frame_start) begin
            acc_left  <= '0;
            acc_right <= '0;
        end else if (mix.valid) begin
            if (mix.to_left) begin
                acc_left <= acc_left + acc_t'(mix.sample);
            end
            if (mix.to_right) begin
                acc_right <= acc_right + acc_t'(mix.sample);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mix_out     <= '0;   // silence.
            mix_pending <= 1'b0;
        end else begin
            if (mix_done) begin
                mix_out.left  <= saturate(acc_left);
                mix_out.right <= saturate(acc_right);
            end
            if (frame_start) begin
                mix_pending <= 1'b1;
            end else if (mix_done) begin
                mix_pending <= 1'b0;
            end
        end
    end

    // the fetch walk of one frame has to end before the next frame begins.
    walk_in_frame: assert property (@(posedge clk) disable iff (!rst)
        frame_start |-> !mix_pending || mix_done);

endmodule

`default_nettype wire

/* hdl/i2s_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_defs.svh"

module i2s_transmitter import audio_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  stereo_t mix_out,
    output logic    frame_start,
    output logic    audio_bclk,
    output logic    audio_lrclk,
    output logic    audio_dout
);

    localparam int frame_bits = 2 * `AUDIO_SAMPLE_WIDTH;
    localparam int slot_w     = $clog2(frame_bits);
    localparam int cnt_w      = $clog2(`AUDIO_BCLK_HALF + 1);

    logic [cnt_w-1:0]      div_cnt;
    logic [slot_w-1:0]     slot;
    logic [slot_w-1:0]     next_slot;
    logic [frame_bits-1:0] shifter;
    logic                  half_tick;
    logic                  fall_tick;

    assign half_tick = (div_cnt == cnt_w'(`AUDIO_BCLK_HALF - 1));
    assign fall_tick = half_tick && audio_bclk;   // bclk about to go low.
    assign next_slot = slot + slot_w'(1);

    always_ff @(posedge clk) begin
        if (!rst) begin
            div_cnt     <= '0;
            slot        <= '1;   // first falling edge opens slot 0.
            shifter     <= '0;
            frame_start <= 1'b0;
            audio_bclk  <= 1'b0;
            audio_lrclk <= 1'b0;
            audio_dout  <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (half_tick) begin
                div_cnt    <= '0;
                audio_bclk <= ~audio_bclk;
            end else begin
                div_cnt <= div_cnt + cnt_w'(1);
            end
            if (fall_tick) begin
                slot <= next_slot;
                // word select leads the data by one bit.
                audio_lrclk <= (next_slot >= slot_w'(`AUDIO_SAMPLE_WIDTH - 1)) &&
                               (next_slot <= slot_w'(frame_bits - 2));
                if (next_slot == '0) begin
                    audio_dout  <= mix_out.left[`AUDIO_SAMPLE_WIDTH-1];
                    shifter     <= {mix_out.left[`AUDIO_SAMPLE_WIDTH-2:0],
                                    mix_out.right, 1'b0};
                    frame_start <= 1'b1;
                end else begin
                    audio_dout <= shifter[frame_bits-1];   // msb first.
                    shifter    <= {shifter[frame_bits-2:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/audio_system.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_defs.svh"

module audio_system import audio_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_write_t ctrl_write,
    output addr_t      araddr,
    output logic       arvalid,
    input  logic       arready,
    input  sample_t    rdata,
    input  logic       rvalid,
    output logic       rready,
    output logic       audio_bclk,
    output logic       audio_lrclk,
    output logic       audio_dout
);

    channel_cfg_t [`AUDIO_CHANNELS-1:0] cfg;
    position_update_t                   pos_update;
    mix_sample_t                        mix;
    logic                               mix_done;
    logic                               frame_start;
    stereo_t                            mix_out;

    channel_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .ctrl_write (ctrl_write),
        .pos_update (pos_update),
        .cfg        (cfg)
    );

    sample_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .cfg         (cfg),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .mix         (mix),
        .mix_done    (mix_done),
        .pos_update  (pos_update)
    );

    channel_mixer u_mixer (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .mix         (mix),
        .mix_done    (mix_done),
        .mix_out     (mix_out)
    );

    i2s_transmitter u_i2s (
        .clk         (clk),
        .rst         (rst),
        .mix_out     (mix_out),
        .frame_start (frame_start),
        .audio_bclk  (audio_bclk),
        .audio_lrclk (audio_lrclk),
        .audio_dout  (audio_dout)
    );

endmodule

`default_nettype wire

/* bench/sample_rom.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_defs.svh"

module sample_rom import audio_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  addr_t   araddr,
    input  logic    arvalid,
    output logic    arready,
    output sample_t rdata,
    output logic    rvalid,
    input  logic    rready
);

    typedef enum logic [1:0] {
        rom_idle,
        rom_addr,
        rom_delay,
        rom_data
    } rom_state_t;

    rom_state_t state;
    logic [1:0] delay;
    logic       ar_done;
    logic       r_done;

    // transfers are seen on the rising edge and answered on the falling one.
    always @(posedge clk) begin
        ar_done <= arvalid && arready;
        r_done  <= rvalid && rready;
    end

    always @(negedge clk) begin
        if (!rst) begin
            state   <= rom_idle;
            delay   <= '0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
        end else begin
            case (state)
                rom_idle: begin
                    if (arvalid) begin
                        delay <= 2'($urandom % 4);
                        state <= rom_addr;
                    end
                end
                rom_addr: begin
                    if (ar_done) begin
                        arready <= 1'b0;
                        delay   <= 2'($urandom % 4);
                        state   <= rom_delay;
                    end else if (delay == 2'd0) begin
                        arready <= 1'b1;
                        rdata   <= sample_t'(araddr[15:0] * 16'd3 + 16'd5);   // word of this address.
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                rom_delay: begin
                    if (delay == 2'd0) begin
                        rvalid <= 1'b1;
                        state  <= rom_data;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                default: begin
                    if (r_done) begin
                        rvalid <= 1'b0;
                        state  <= rom_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* bench/audio_system_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "audio_defs.svh"

module audio_system_tb import audio_pkg::*; ();

    localparam int frame_cycles   = 2 * 2 * `AUDIO_SAMPLE_WIDTH * `AUDIO_BCLK_HALF;
    localparam int timeout_cycles = 40 * frame_cycles + 1000;

    logic       clk = 1'b1;
    logic       rst;
    reg_write_t ctrl_write;
    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    sample_t    rdata;
    logic       rvalid;
    logic       rready;
    logic       audio_bclk;
    logic       audio_lrclk;
    logic       audio_dout;

    channel_cfg_t shadow [0:`AUDIO_CHANNELS-1];   // model of the register bank.
    stereo_t      expected [0:63];                 // predicted pair per frame.
    stereo_t      cap_pair;
    stereo_t      exp_pair;
    logic [31:0]  shift_in;
    logic         bclk_q = 1'b0;
    logic         lr_prev = 1'b0;
    logic         rst_q = 1'b0;
    logic         check_valid = 1'b0;
    int           frame_count = 0;
    int           check_frame = 0;
    int           cycles = 0;

    audio_system dut (
        .clk         (clk),
        .rst         (rst),
        .ctrl_write  (ctrl_write),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rvalid      (rvalid),
        .rready      (rready),
        .audio_bclk  (audio_bclk),
        .audio_lrclk (audio_lrclk),
        .audio_dout  (audio_dout)
    );

    sample_rom rom (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #2 clk = ~clk;

    // deserialize on rising bclk; a high to low lrclk marks the last right bit.
    always @(posedge clk) begin
        rst_q       <= rst;
        bclk_q      <= audio_bclk;
        check_valid <= 1'b0;
        if (audio_bclk && !bclk_q) begin
            shift_in <= {shift_in[30:0], audio_dout};
            lr_prev  <= audio_lrclk;
            if (lr_prev && !audio_lrclk) begin
                check_valid <= 1'b1;
                cap_pair    <= {shift_in[30:0], audio_dout};
                exp_pair    <= expected[frame_count];
                check_frame <= frame_count;
                frame_count <= frame_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the run did not end within %0d cycles", timeout_cycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    quiet_after_reset: assert property (@(posedge clk)
        rst && !rst_q |-> !audio_bclk && !audio_lrclk && !audio_dout)
        else begin
            $display("ERR %0t: I2S outputs not low after reset", $time);
            $display("test failed");
            $fatal(1, "outputs after reset");
        end

    frame_match: assert property (@(posedge clk) disable iff (!rst)
        check_valid |-> cap_pair == exp_pair)
        else begin
            $display("ERR %0t: frame %0d expected L %0d R %0d, captured L %0d R %0d",
                     $time, check_frame, $signed(exp_pair.left), $signed(exp_pair.right),
                     $signed(cap_pair.left), $signed(cap_pair.right));
            $display("test failed");
            $fatal(1, "frame mismatch");
        end

    function automatic sample_t clip_to_sample(input int value);
        if (value > 32767) begin
            return sample_t'(16'h7fff);
        end else if (value < -32768) begin
            return sample_t'(16'h8000);
        end
        return sample_t'(value);
    endfunction

    task automatic write_reg(input int ch, input reg_sel_t sel, input logic [31:0] data);
        ctrl_write = '{valid: 1'b1, channel: chan_t'(ch), select: sel, data: data};
        case (sel)
            set_start_address:    shadow[ch].start_address = addr_t'(data);
            set_sample_count:     shadow[ch].sample_count = addr_t'(data);
            set_loop_start:       shadow[ch].loop_start = addr_t'(data);
            set_loop_end:         shadow[ch].loop_end = addr_t'(data);
            set_current_position: shadow[ch].position = addr_t'(data);
            set_volume:           shadow[ch].volume = volume_t'(data);
            set_is_looping:       shadow[ch].is_looping = data[0];
            set_is_playing:       shadow[ch].is_playing = data[0];
            set_is_mono:          shadow[ch].is_mono = data[0];
            default:              shadow[ch].is_right = data[0];
        endcase
        @(negedge clk);
        ctrl_write.valid = 1'b0;
    endtask

    task automatic setup_channel(input int ch, input logic [31:0] start, input logic [31:0] count,
                                 input logic [31:0] lstart, input logic [31:0] lend,
                                 input logic [31:0] vol, input logic looping,
                                 input logic mono, input logic right);
        write_reg(ch, set_start_address, start);
        write_reg(ch, set_sample_count, count);
        write_reg(ch, set_loop_start, lstart);
        write_reg(ch, set_loop_end, lend);
        write_reg(ch, set_current_position, 32'd0);
        write_reg(ch, set_volume, vol);
        write_reg(ch, set_is_looping, 32'(looping));
        write_reg(ch, set_is_mono, 32'(mono));
        write_reg(ch, set_is_right, 32'(right));
    endtask

    // the walk after this window shows up two frames later on the pins.
    task automatic predict_walk();
        int      sum_left;
        int      sum_right;
        int      scaled;
        int      idx;
        addr_t   addr;
        sample_t word;
        sum_left  = 0;
        sum_right = 0;
        for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
            if (shadow[c].is_playing) begin
                addr   = shadow[c].start_address + shadow[c].position;
                word   = sample_t'(addr * 3 + 5);
                scaled = (int'(word) * int'(shadow[c].volume)) >>> 8;
                if (shadow[c].is_mono || !shadow[c].is_right) begin
                    sum_left += scaled;
                end
                if (shadow[c].is_mono || shadow[c].is_right) begin
                    sum_right += scaled;
                end
                if (shadow[c].is_looping && shadow[c].position == shadow[c].loop_end) begin
                    shadow[c].position = shadow[c].loop_start;
                end else if (shadow[c].position == shadow[c].sample_count - addr_t'(1)) begin
                    shadow[c].is_playing = 1'b0;
                end else begin
                    shadow[c].position = shadow[c].position + addr_t'(1);
                end
            end
        end
        idx = frame_count + 2;
        expected[idx].left  = clip_to_sample(sum_left);
        expected[idx].right = clip_to_sample(sum_right);
    endtask

    // mid frame, after the walk and well before the next one.
    task automatic next_window();
        @(posedge audio_lrclk);
        @(negedge clk);
    endtask

    task automatic run_frames(input int count);
        repeat (count) begin
            predict_walk();
            next_window();
        end
    endtask

    initial begin
        int target;
        void'($urandom(32'h8889_7014));
        ctrl_write = '0;
        rst        = 1'b0;
        for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
            shadow[c] = '0;
        end
        for (int f = 0; f < 64; f++) begin
            expected[f] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        next_window();
        run_frames(2);   // nothing playing.
        setup_channel(0, 'h100, 100, 0, 0, 255, 1'b0, 1'b1, 1'b0);
        write_reg(0, set_is_playing, 32'd1);
        run_frames(6);
        write_reg(0, set_is_playing, 32'd0);
        setup_channel(1, 'h200, 100, 0, 0, 255, 1'b0, 1'b0, 1'b0);
        setup_channel(2, 'h300, 100, 0, 0, 128, 1'b0, 1'b0, 1'b1);
        write_reg(1, set_is_playing, 32'd1);
        write_reg(2, set_is_playing, 32'd1);
        run_frames(4);   // one channel per side.
        write_reg(1, set_is_playing, 32'd0);
        write_reg(2, set_is_playing, 32'd0);
        setup_channel(3, 'h400, 100, 2, 6, 200, 1'b1, 1'b1, 1'b0);
        write_reg(3, set_is_playing, 32'd1);
        run_frames(10);
        write_reg(3, set_is_playing, 32'd0);
        setup_channel(0, 'h500, 5, 0, 0, 255, 1'b0, 1'b1, 1'b0);
        write_reg(0, set_is_playing, 32'd1);
        run_frames(7);   // five samples, then silence.
        for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
            setup_channel(c, 'h2a00, 100, 0, 0, 255, 1'b0, 1'b1, 1'b0);
        end
        for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
            write_reg(c, set_is_playing, 32'd1);
        end
        run_frames(3);   // large words on every channel clip.
        for (int c = 0; c < `AUDIO_CHANNELS; c++) begin
            write_reg(c, set_is_playing, 32'd0);
        end
        run_frames(2);
        target = frame_count + 2;
        while (frame_count < target) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/audio_pkg.sv
hdl/channel_regs.sv
hdl/sample_fetch.sv
hdl/channel_mixer.sv
hdl/i2s_transmitter.sv
hdl/audio_system.sv
bench/sample_rom.sv
bench/audio_system_tb.sv

/* Makefile */
TOP := audio_system_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
